//--- hw/fabric_pkg.sv
package fabric_pkg;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  // Area prefix in address bits 31:30
  localparam logic [1:0] area_rom      = 2'd0;
  localparam logic [1:0] area_ram      = 2'd1;
  localparam logic [1:0] area_reserved = 2'd2;
  localparam logic [1:0] area_mmio     = 2'd3;

  // Register-file cores sit on core prefixes 0 and up
  localparam int n_regfiles = 4;

  // System control core prefix in address bits 29:24
  localparam logic [5:0] ctrl_prefix = 6'h3f;

  // Memory sizes in 32-bit words
  localparam int ram_words     = 256;
  localparam int ram_addr_bits = 8;
  localparam int rom_words     = 16;

  // --------------------------------------------------------------------------
  // Request and select types
  // --------------------------------------------------------------------------
  // Held request as seen by every target
  typedef struct packed {
    logic                     we;
    logic [3:0]               wstrb;
    logic [ram_addr_bits-1:0] word_addr;
    logic [31:0]              wdata;
  } bus_req_t;

  typedef enum logic [2:0] {
    sel_idle,
    sel_zero,
    sel_rom,
    sel_ram,
    sel_reg,
    sel_ctrl
  } sel_kind_t;

  // Target chosen by the decoder, index only meaningful for sel_reg
  typedef struct packed {
    sel_kind_t                       kind;
    logic [$clog2(n_regfiles)-1:0]   index;
  } target_sel_t;

endpackage

//--- hw/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
  input  logic                              mem_valid,
  input  logic [31:0]                       mem_addr,
  input  logic [31:0]                       mem_wdata,
  input  logic [3:0]                        mem_wstrb,
  input  logic                              mem_ready,
  input  logic                              app_mode,
  output fabric_pkg::bus_req_t              req,
  output logic                              rom_cs,
  output logic                              ram_cs,
  output logic [fabric_pkg::n_regfiles-1:0] reg_cs,
  output logic                              ctrl_cs,
  output fabric_pkg::target_sel_t           sel
);

  logic [1:0] area_prefix;
  logic [5:0] core_prefix;
  logic       accept;

  assign area_prefix = mem_addr[31:30];
  assign core_prefix = mem_addr[29:24];

  // New request only until the registered ready comes back
  assign accept = mem_valid && !mem_ready;

  assign req.we        = |mem_wstrb;
  assign req.wstrb     = mem_wstrb;
  assign req.word_addr = mem_addr[fabric_pkg::ram_addr_bits+1:2];
  assign req.wdata     = mem_wdata;

  always_comb begin
    rom_cs    = 1'b0;
    ram_cs    = 1'b0;
    reg_cs    = '0;
    ctrl_cs   = 1'b0;
    sel.kind  = fabric_pkg::sel_idle;
    sel.index = core_prefix[$clog2(fabric_pkg::n_regfiles)-1:0];

    if (accept) begin
      case (area_prefix)
        fabric_pkg::area_rom: begin
          // ROM hidden once the application runs
          if (app_mode) begin
            sel.kind = fabric_pkg::sel_zero;
          end else begin
            rom_cs   = 1'b1;
            sel.kind = fabric_pkg::sel_rom;
          end
        end
        fabric_pkg::area_ram: begin
          ram_cs   = 1'b1;
          sel.kind = fabric_pkg::sel_ram;
        end
        fabric_pkg::area_mmio: begin
          if (core_prefix < 6'(fabric_pkg::n_regfiles)) begin
            reg_cs[sel.index] = 1'b1;
            sel.kind          = fabric_pkg::sel_reg;
          end else if (core_prefix == fabric_pkg::ctrl_prefix) begin
            ctrl_cs  = 1'b1;
            sel.kind = fabric_pkg::sel_ctrl;
          end else begin
            sel.kind = fabric_pkg::sel_zero;
          end
        end
        // Reserved area
        default: sel.kind = fabric_pkg::sel_zero;
      endcase
    end
  end

endmodule

//--- hw/mmio_regfile.sv
`timescale 1ns/1ps

module mmio_regfile (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 cs,
  input  fabric_pkg::bus_req_t req,
  output logic [31:0]          read_data,
  output logic                 ready
);

  logic [31:0] regs [4];
  logic [1:0]  reg_idx;

  // Only the low two word-address bits pick a register
  assign reg_idx = req.word_addr[1:0];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (cs && req.we) begin
      // Whole word, strobes not honoured here
      regs[reg_idx] <= req.wdata;
    end
  end

  assign read_data = regs[reg_idx];

  // Answers in the same cycle
  assign ready = cs;

endmodule

//--- hw/sys_ctrl.sv
`timescale 1ns/1ps

module sys_ctrl (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cs,
  input  fabric_pkg::bus_req_t                 req,
  output logic [31:0]                          read_data,
  output logic                                 ready,
  output logic [fabric_pkg::ram_addr_bits-1:0] ram_aslr,
  output logic [31:0]                          ram_scramble,
  output logic                                 app_mode
);

  logic write_en;

  assign write_en = cs && req.we;

  // --------------------------------------------------------------------------
  // Key and mode registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ram_aslr     <= '0;
      ram_scramble <= '0;
      app_mode     <= 1'b0;
    end else if (write_en) begin
      case (req.word_addr)
        8'd0: begin
          if (!app_mode) begin
            ram_aslr <= req.wdata[fabric_pkg::ram_addr_bits-1:0];
          end
        end
        8'd1: begin
          if (!app_mode) begin
            ram_scramble <= req.wdata;
          end
        end
        // Sticky until reset, any data value sets it
        8'd2: app_mode <= 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (req.word_addr)
      8'd0:    read_data = 32'(ram_aslr);
      8'd1:    read_data = ram_scramble;
      8'd2:    read_data = {31'd0, app_mode};
      default: read_data = '0;
    endcase
  end

  assign ready = cs;

endmodule

//--- hw/scrambled_ram.sv
`timescale 1ns/1ps

module scrambled_ram (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cs,
  input  fabric_pkg::bus_req_t                 req,
  input  logic [fabric_pkg::ram_addr_bits-1:0] ram_aslr,
  input  logic [31:0]                          ram_scramble,
  output logic [31:0]                          read_data,
  output logic                                 ready
);

  logic [31:0]                          mem [fabric_pkg::ram_words];
  logic [fabric_pkg::ram_addr_bits-1:0] phys_addr;
  logic [31:0]                          addr_pattern;
  logic [31:0]                          write_word;
  logic [31:0]                          mem_q;

  // Randomised physical location
  assign phys_addr = req.word_addr ^ ram_aslr;

  // Low 16 bits of the byte address, repeated in both halves
  assign addr_pattern = {2{16'({req.word_addr, 2'b00})}};

  assign write_word = req.wdata ^ ram_scramble ^ addr_pattern;

  always_ff @(posedge clk) begin
    if (cs) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[phys_addr][8*b +: 8] <= write_word[8*b +: 8];
        end
      end
      mem_q <= mem[phys_addr];
    end
  end

  // One cycle behind the select, like the read data
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

  // Descramble with the keys in force now
  assign read_data = mem_q ^ ram_scramble ^ addr_pattern;

endmodule

//--- hw/boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
  input  logic                 cs,
  input  fabric_pkg::bus_req_t req,
  output logic [31:0]          read_data,
  output logic                 ready
);

  logic [31:0] rom [fabric_pkg::rom_words];

  initial begin
    $readmemh("boot_rom.hex", rom);
  end

  // Data only while selected
  assign read_data = cs ? rom[req.word_addr[$clog2(fabric_pkg::rom_words)-1:0]] : '0;

  assign ready = 1'b1;

endmodule

//--- hw/resp_mux.sv
`timescale 1ns/1ps

module resp_mux (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  fabric_pkg::target_sel_t                 sel,
  input  logic [31:0]                             rom_rdata,
  input  logic                                    rom_ready,
  input  logic [31:0]                             ram_rdata,
  input  logic                                    ram_ready,
  input  logic [fabric_pkg::n_regfiles-1:0][31:0] reg_rdata,
  input  logic [fabric_pkg::n_regfiles-1:0]       reg_ready,
  input  logic [31:0]                             ctrl_rdata,
  input  logic                                    ctrl_ready,
  output logic [31:0]                             mem_rdata,
  output logic                                    mem_ready
);

  logic [31:0] rdata_next;
  logic        ready_next;

  always_comb begin
    rdata_next = '0;
    ready_next = 1'b0;
    case (sel.kind)
      fabric_pkg::sel_zero: ready_next = 1'b1;
      fabric_pkg::sel_rom: begin
        rdata_next = rom_rdata;
        ready_next = rom_ready;
      end
      fabric_pkg::sel_ram: begin
        rdata_next = ram_rdata;
        ready_next = ram_ready;
      end
      fabric_pkg::sel_reg: begin
        rdata_next = reg_rdata[sel.index];
        ready_next = reg_ready[sel.index];
      end
      fabric_pkg::sel_ctrl: begin
        rdata_next = ctrl_rdata;
        ready_next = ctrl_ready;
      end
      // Idle keeps zero data and no ready
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_rdata <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_rdata <= rdata_next;
      mem_ready <= ready_next;
    end
  end

endmodule

//--- hw/mmio_fabric_top.sv
`timescale 1ns/1ps

module mmio_fabric_top (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic        app_mode
);

  // --------------------------------------------------------------------------
  // Fabric wiring
  // --------------------------------------------------------------------------
  fabric_pkg::bus_req_t                 req;
  fabric_pkg::target_sel_t              sel;

  logic                                 rom_cs;
  logic [31:0]                          rom_rdata;
  logic                                 rom_ready;

  logic                                 ram_cs;
  logic [31:0]                          ram_rdata;
  logic                                 ram_ready;

  logic [fabric_pkg::n_regfiles-1:0]       reg_cs;
  logic [fabric_pkg::n_regfiles-1:0][31:0] reg_rdata;
  logic [fabric_pkg::n_regfiles-1:0]       reg_ready;

  logic                                 ctrl_cs;
  logic [31:0]                          ctrl_rdata;
  logic                                 ctrl_ready;

  // Keys from system control into the RAM
  logic [fabric_pkg::ram_addr_bits-1:0] ram_aslr;
  logic [31:0]                          ram_scramble;

  bus_decode u_bus_decode (
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .app_mode  (app_mode),
    .req       (req),
    .rom_cs    (rom_cs),
    .ram_cs    (ram_cs),
    .reg_cs    (reg_cs),
    .ctrl_cs   (ctrl_cs),
    .sel       (sel)
  );

  boot_rom u_boot_rom (
    .cs        (rom_cs),
    .req       (req),
    .read_data (rom_rdata),
    .ready     (rom_ready)
  );

  scrambled_ram u_scrambled_ram (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (ram_cs),
    .req          (req),
    .ram_aslr     (ram_aslr),
    .ram_scramble (ram_scramble),
    .read_data    (ram_rdata),
    .ready        (ram_ready)
  );

  // One register file per low core prefix
  for (genvar i = 0; i < fabric_pkg::n_regfiles; i++) begin : g_regfile
    mmio_regfile u_mmio_regfile (
      .clk       (clk),
      .reset_n   (reset_n),
      .cs        (reg_cs[i]),
      .req       (req),
      .read_data (reg_rdata[i]),
      .ready     (reg_ready[i])
    );
  end

  sys_ctrl u_sys_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (ctrl_cs),
    .req          (req),
    .read_data    (ctrl_rdata),
    .ready        (ctrl_ready),
    .ram_aslr     (ram_aslr),
    .ram_scramble (ram_scramble),
    .app_mode     (app_mode)
  );

  resp_mux u_resp_mux (
    .clk        (clk),
    .reset_n    (reset_n),
    .sel        (sel),
    .rom_rdata  (rom_rdata),
    .rom_ready  (rom_ready),
    .ram_rdata  (ram_rdata),
    .ram_ready  (ram_ready),
    .reg_rdata  (reg_rdata),
    .reg_ready  (reg_ready),
    .ctrl_rdata (ctrl_rdata),
    .ctrl_ready (ctrl_ready),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready)
  );

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic reset_n
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Reset released on a rising edge
  initial begin
    reset_n <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

//--- bench/tb_mmio_fabric.sv
`timescale 1ns/1ps

module tb_mmio_fabric;

  // About 140 transfers of at most four edges each, plus reset, with wide margin
  localparam int timeout_cycles = 2000;

  logic        clk;
  logic        reset_n;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        app_mode;

  int seed = 29;
  int cycle_count;
  int check_count;
  int error_count;
  int test_start_errors;

  // Reference data for every target
  logic [31:0] rom_ref   [fabric_pkg::rom_words];
  logic [31:0] reg_model [fabric_pkg::n_regfiles][4];
  logic [31:0] ram_phys  [fabric_pkg::ram_words];
  logic [7:0]  aslr_key;
  logic [31:0] scramble_key;

  clk_gen u_clk_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  mmio_fabric_top u_mmio_fabric_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .app_mode  (app_mode)
  );

  // --------------------------------------------------------------------------
  // Protocol checks and timeout
  // --------------------------------------------------------------------------
  // Ready is a single-cycle pulse per transfer
  ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    mem_ready |=> !mem_ready)
    else begin
      error_count++;
      $display("FAIL at %0t: mem_ready high for two cycles in a row", $time);
    end

  mode_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    app_mode |=> app_mode)
    else begin
      error_count++;
      $display("FAIL at %0t: app_mode dropped without reset", $time);
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Address map and reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] rom_addr(input int word);
    return {fabric_pkg::area_rom, 24'd0, 4'(word), 2'b00};
  endfunction

  function automatic logic [31:0] ram_addr(input int word);
    return {fabric_pkg::area_ram, 20'd0, 8'(word), 2'b00};
  endfunction

  function automatic logic [31:0] reg_addr(input int core, input int word);
    return {fabric_pkg::area_mmio, 6'(core), 16'd0, 6'(word), 2'b00};
  endfunction

  function automatic logic [31:0] ctrl_addr(input int word);
    return {fabric_pkg::area_mmio, fabric_pkg::ctrl_prefix, 16'd0, 6'(word), 2'b00};
  endfunction

  // Low half of the byte address in both halves
  function automatic logic [31:0] scramble_pattern(input int word);
    logic [15:0] byte_addr;
    byte_addr = 16'(word * 4);
    return {byte_addr, byte_addr};
  endfunction

  function automatic void model_ram_write(input int word, input logic [31:0] data,
                                          input logic [3:0] strb);
    logic [7:0]  phys;
    logic [31:0] stored;
    phys   = 8'(word) ^ aslr_key;
    stored = data ^ scramble_key ^ scramble_pattern(word);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ram_phys[phys][8*b +: 8] = stored[8*b +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] ram_expect(input int word);
    return ram_phys[8'(word) ^ aslr_key] ^ scramble_key ^ scramble_pattern(word);
  endfunction

  // --------------------------------------------------------------------------
  // Bus master
  // --------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    assert (got === expected)
      else begin
        error_count++;
        $display("FAIL at %0t: %s is %08h, expected %08h", $time, what, got, expected);
      end
  endtask

  // Latency counts edges from the drive edge up to the one that raised ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int latency);
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= wstrb;
    latency = 0;
    do begin
      @(posedge clk);
      latency++;
      @(negedge clk);
    end while (!mem_ready);
    rdata = mem_rdata;
    @(posedge clk);
    mem_valid <= 1'b0;
    mem_wstrb <= 4'h0;
  endtask

  task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int exp_latency);
    logic [31:0] rdata;
    int          latency;
    bus_access(addr, data, strb, rdata, latency);
    check_value("write latency", 32'(latency), 32'(exp_latency));
  endtask

  task automatic read_expect(input string what, input logic [31:0] addr,
                             input logic [31:0] expected, input int exp_latency);
    logic [31:0] rdata;
    int          latency;
    bus_access(addr, 32'd0, 4'h0, rdata, latency);
    check_value(what, rdata, expected);
    check_value({what, " latency"}, 32'(latency), 32'(exp_latency));
  endtask

  task automatic set_keys(input logic [7:0] aslr, input logic [31:0] scramble);
    write_access(ctrl_addr(0), {24'd0, aslr}, 4'hf, 1);
    write_access(ctrl_addr(1), scramble, 4'hf, 1);
    aslr_key     = aslr;
    scramble_key = scramble;
  endtask

  task automatic end_test(input int number, input string name);
    $display("test %0d %s: %0d errors", number, name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] data;
    logic [3:0]  strb;
    logic [3:0]  aslr_delta;
    logic [7:0]  new_aslr;

    mem_valid <= 1'b0;
    mem_addr  <= '0;
    mem_wdata <= '0;
    mem_wstrb <= '0;
    aslr_key     = '0;
    scramble_key = '0;
    $readmemh("boot_rom.hex", rom_ref);

    wait (reset_n === 1'b1);
    @(negedge clk);

    check_value("mem_ready after reset", {31'd0, mem_ready}, 32'd0);
    check_value("mem_rdata after reset", mem_rdata, 32'd0);
    check_value("app_mode after reset", {31'd0, app_mode}, 32'd0);
    for (int w = 0; w < fabric_pkg::rom_words; w++) begin
      read_expect("rom word", rom_addr(w), rom_ref[w], 1);
    end
    end_test(1, "boot rom");

    for (int c = 0; c < fabric_pkg::n_regfiles; c++) begin
      for (int w = 0; w < 4; w++) begin
        data = $random(seed);
        write_access(reg_addr(c, w), data, 4'hf, 1);
        reg_model[c][w] = data;
      end
    end
    // Read only after all cores were written, so crosstalk shows up
    for (int c = 0; c < fabric_pkg::n_regfiles; c++) begin
      for (int w = 0; w < 4; w++) begin
        read_expect("regfile word", reg_addr(c, w), reg_model[c][w], 1);
      end
    end
    end_test(2, "register files");

    set_keys(8'($random(seed)), $random(seed));
    for (int a = 0; a < 16; a++) begin
      data = $random(seed);
      write_access(ram_addr(a), data, 4'hf, 2);
      model_ram_write(a, data, 4'hf);
    end
    for (int a = 0; a < 16; a++) begin
      data = $random(seed);
      strb = 4'($random(seed));
      if (strb == 4'h0) begin
        strb = 4'h1;
      end
      write_access(ram_addr(a), data, strb, 2);
      model_ram_write(a, data, strb);
    end
    for (int a = 0; a < 16; a++) begin
      read_expect("ram word", ram_addr(a), ram_expect(a), 2);
    end
    end_test(3, "ram byte writes");

    // New ASLR key moves only the low four bits, so words 0 to 15 stay filled
    aslr_delta = 4'($random(seed));
    if (aslr_delta == 4'h0) begin
      aslr_delta = 4'h1;
    end
    new_aslr = aslr_key ^ {4'h0, aslr_delta};
    set_keys(new_aslr, $random(seed));
    read_expect("aslr key", ctrl_addr(0), {24'd0, aslr_key}, 1);
    read_expect("scramble key", ctrl_addr(1), scramble_key, 1);
    for (int a = 0; a < 16; a++) begin
      read_expect("ram word after rekey", ram_addr(a), ram_expect(a), 2);
    end
    end_test(4, "ram key change");

    read_expect("reserved read", {fabric_pkg::area_reserved, 30'h10}, 32'd0, 1);
    read_expect("unmapped read", reg_addr(4, 0), 32'd0, 1);
    read_expect("unmapped read", reg_addr(32, 1), 32'd0, 1);
    read_expect("unmapped read", reg_addr(62, 2), 32'd0, 1);
    write_access({fabric_pkg::area_reserved, 30'h0}, $random(seed), 4'hf, 1);
    write_access(reg_addr(4, 0), $random(seed), 4'hf, 1);
    for (int w = 0; w < 4; w++) begin
      read_expect("regfile 0 after stray write", reg_addr(0, w), reg_model[0][w], 1);
    end
    read_expect("ram after stray write", ram_addr(0), ram_expect(0), 2);
    end_test(5, "reserved and unmapped");

    write_access(ctrl_addr(2), 32'd1, 4'hf, 1);
    @(negedge clk);
    check_value("app_mode after mode write", {31'd0, app_mode}, 32'd1);
    read_expect("mode word", ctrl_addr(2), 32'd1, 1);
    // Locked keys leave the model unchanged
    write_access(ctrl_addr(0), {24'd0, ~aslr_key}, 4'hf, 1);
    write_access(ctrl_addr(1), ~scramble_key, 4'hf, 1);
    read_expect("locked aslr key", ctrl_addr(0), {24'd0, aslr_key}, 1);
    read_expect("locked scramble key", ctrl_addr(1), scramble_key, 1);
    read_expect("rom in app mode", rom_addr(0), 32'd0, 1);
    read_expect("rom in app mode", rom_addr(9), 32'd0, 1);
    end_test(6, "application mode");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- boot_rom.hex
// Boot ROM image: one 32-bit word per line in hex, words 0 to 15 in order
00000297
02028293
30529073
00001137
ff010113
0040006f
c0de0001
13579bdf
2468ace0
a5a5f00f
0badcafe
5a5a0ff0
00c0ffee
8badf00d
7e57ab1e
fee1dead

//--- mmio_fabric.f
hw/fabric_pkg.sv
hw/bus_decode.sv
hw/mmio_regfile.sv
hw/sys_ctrl.sv
hw/scrambled_ram.sv
hw/boot_rom.sv
hw/resp_mux.sv
hw/mmio_fabric_top.sv
bench/clk_gen.sv
bench/tb_mmio_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the fabric testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_mmio_fabric -Mdir obj_dir -f mmio_fabric.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mmio_fabric)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
